//--- include/mem_defines.svh
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

//////////////////////////////////////////////////
// Back end sizing
//////////////////////////////////////////////////

// Datapath and address width
`define MW_XLEN 32

// Register number width, x0..x31
`define MW_REG_BITS 5

// Data memory depth in 32-bit words
`define MW_MEM_WORDS 1024

// Word index width, log2 of the depth
`define MW_MEM_ADDR_BITS 10

`endif

//--- hdl/mem_pkg.sv
`include "mem_defines.svh"

package mem_pkg;

  //////////////////////////////////////////////////
  // Control encodings
  //////////////////////////////////////////////////

  // Store kind, one-hot, zero for a non-store
  typedef enum logic [2:0] {
    st_none = 3'b000,
    st_sb   = 3'b001,
    st_sh   = 3'b010,
    st_sw   = 3'b100
  } store_ctrl_e;

  // Load kind, one-hot, zero for a non-load
  typedef enum logic [4:0] {
    ld_none = 5'b00000,
    ld_lb   = 5'b00001,
    ld_lh   = 5'b00010,
    ld_lw   = 5'b00100,
    ld_lbu  = 5'b01000,
    ld_lhu  = 5'b10000
  } load_ctrl_e;

  //////////////////////////////////////////////////
  // Pipeline records
  //////////////////////////////////////////////////

  // EX/MEM record from the execute stage
  typedef struct packed {
    logic [`MW_XLEN-1:0]     alures;
    logic [`MW_XLEN-1:0]     rs2_data;
    logic [`MW_REG_BITS-1:0] rs2;
    logic [`MW_REG_BITS-1:0] rd;
    logic                    regwrite;
    logic                    memread;
    logic                    memwrite;
    store_ctrl_e             storectrl;
    load_ctrl_e              loadctrl;
    logic [`MW_XLEN-1:0]     mulres;
    logic                    mul_ready;
    logic [`MW_XLEN-1:0]     divres;
    logic                    div_ready;
  } ex_mem_t;

  // MEM/WB record, registered in the memory stage
  typedef struct packed {
    logic [`MW_XLEN-1:0]     alures;
    logic [`MW_XLEN-1:0]     mulres;
    logic                    mul_ready;
    logic [`MW_XLEN-1:0]     divres;
    logic                    div_ready;
    logic                    memread;
    logic                    regwrite;
    logic [`MW_REG_BITS-1:0] rd;
    load_ctrl_e              loadctrl;
  } mem_wb_t;

  // Data memory request
  typedef struct packed {
    logic                wr;
    logic                rd;
    logic [3:0]          byte_en;
    logic [`MW_XLEN-1:0] addr;
    logic [`MW_XLEN-1:0] wdata;
  } mem_req_t;

  // Register file write port
  typedef struct packed {
    logic                    we;
    logic [`MW_REG_BITS-1:0] rd;
    logic [`MW_XLEN-1:0]     data;
  } reg_wr_t;

endpackage

//--- hdl/mem_stage.sv
`timescale 1ns/100ps
`include "mem_defines.svh"

module mem_stage (
  input  logic                bus,
  input  logic                rst,
  input  logic                hold,
  input  mem_pkg::ex_mem_t    ex_mem,
  input  logic [`MW_XLEN-1:0] rdata,
  input  logic [`MW_XLEN-1:0] wb_res,
  output mem_pkg::mem_req_t   mem_req,
  output mem_pkg::mem_wb_t    mem_wb,
  output logic [`MW_XLEN-1:0] memres
);

  logic [3:0]          byte_en;
  logic                fwd_store;
  logic [`MW_XLEN-1:0] store_data;
  mem_pkg::mem_wb_t    mem_wb_d;

  //////////////////////////////////////////////////
  // Store lane decode
  //////////////////////////////////////////////////

  // Lanes are counted from the addressed byte upward
  // A halfword at offset 3 wraps into lane 0
  always_comb begin
    case (ex_mem.storectrl)
      mem_pkg::st_sb: begin
        case (ex_mem.alures[1:0])
          2'b00:   byte_en = 4'b0001;
          2'b01:   byte_en = 4'b0010;
          2'b10:   byte_en = 4'b0100;
          default: byte_en = 4'b1000;
        endcase
      end
      mem_pkg::st_sh: begin
        case (ex_mem.alures[1:0])
          2'b00:   byte_en = 4'b0011;
          2'b01:   byte_en = 4'b0110;
          2'b10:   byte_en = 4'b1100;
          default: byte_en = 4'b1001;
        endcase
      end
      // Full word, also the idle pattern
      mem_pkg::st_sw:   byte_en = 4'b1111;
      mem_pkg::st_none: byte_en = 4'b1111;
      default:          byte_en = 4'b1111;
    endcase
  end

  //////////////////////////////////////////////////
  // Store forwarding and memory request
  //////////////////////////////////////////////////

  // Load followed by a dependent store
  // MEM/WB result replaces the stale rs2 value
  assign fwd_store = ex_mem.memwrite && mem_wb.regwrite && (mem_wb.rd == ex_mem.rs2);

  assign store_data = fwd_store ? wb_res : ex_mem.rs2_data;

  // Strobes drop while the pipe is frozen
  assign mem_req.wr      = ex_mem.memwrite && !hold;
  assign mem_req.rd      = ex_mem.memread && !hold;
  assign mem_req.byte_en = byte_en;
  assign mem_req.addr    = ex_mem.alures;
  assign mem_req.wdata   = store_data;

  //////////////////////////////////////////////////
  // MEM/WB register
  //////////////////////////////////////////////////

  always_comb begin
    mem_wb_d.alures    = ex_mem.alures;
    mem_wb_d.mulres    = ex_mem.mulres;
    mem_wb_d.mul_ready = ex_mem.mul_ready;
    mem_wb_d.divres    = ex_mem.divres;
    mem_wb_d.div_ready = ex_mem.div_ready;
    mem_wb_d.memread   = ex_mem.memread;
    mem_wb_d.regwrite  = ex_mem.regwrite;
    mem_wb_d.rd        = ex_mem.rd;
    mem_wb_d.loadctrl  = ex_mem.loadctrl;
  end

  // Only control fields are cleared
  always_ff @(posedge bus) begin
    if (rst) begin
      mem_wb.regwrite  <= 1'b0;
      mem_wb.memread   <= 1'b0;
      mem_wb.mul_ready <= 1'b0;
      mem_wb.div_ready <= 1'b0;
      mem_wb.loadctrl  <= mem_pkg::ld_none;
    end else if (!hold) begin
      mem_wb <= mem_wb_d;
    end
  end

  //////////////////////////////////////////////////
  // Load extension
  //////////////////////////////////////////////////

  // rdata already has the addressed byte at bit 0
  always_comb begin
    case (mem_wb.loadctrl)
      mem_pkg::ld_lb:  memres = {{24{rdata[7]}}, rdata[7:0]};
      mem_pkg::ld_lh:  memres = {{16{rdata[15]}}, rdata[15:0]};
      mem_pkg::ld_lw:  memres = rdata;
      mem_pkg::ld_lbu: memres = {24'h0, rdata[7:0]};
      mem_pkg::ld_lhu: memres = {16'h0, rdata[15:0]};
      // Not a load, or a bad code
      default:         memres = '0;
    endcase
  end

  // A record is either a load or a store, never both
  a_rd_wr_excl: assert property (@(posedge bus) disable iff (rst)
    !(ex_mem.memread && ex_mem.memwrite))
    else $error("EX/MEM record has memread and memwrite both set");

  // Store kind must decode to a single lane pattern
  a_store_onehot: assert property (@(posedge bus) disable iff (rst)
    ex_mem.memwrite |-> $onehot0(ex_mem.storectrl))
    else $error("EX/MEM storectrl is not one-hot");

endmodule

//--- hdl/data_mem.sv
`timescale 1ns/100ps
`include "mem_defines.svh"

module data_mem (
  input  logic                bus,
  input  mem_pkg::mem_req_t   mem_req,
  output logic [`MW_XLEN-1:0] rdata
);

  logic [`MW_MEM_ADDR_BITS-1:0] word_idx;
  logic [1:0]                   wr_rot;
  logic [`MW_XLEN-1:0]          wdata_rot;
  logic [7:0]                   rd_lane [4];
  logic [1:0]                   rd_off;
  logic [`MW_XLEN-1:0]          rd_word;

  // Rotate a word right by whole bytes
  function automatic logic [`MW_XLEN-1:0] rot_right_bytes(
    input logic [`MW_XLEN-1:0] w,
    input logic [1:0]          n
  );
    case (n)
      2'd0:    return w;
      2'd1:    return {w[7:0], w[`MW_XLEN-1:8]};
      2'd2:    return {w[15:0], w[`MW_XLEN-1:16]};
      default: return {w[23:0], w[`MW_XLEN-1:24]};
    endcase
  endfunction

  assign word_idx = mem_req.addr[`MW_MEM_ADDR_BITS+1:2];

  // Left rotate by the offset, done as a right rotate by its complement
  assign wr_rot    = 2'd0 - mem_req.addr[1:0];
  assign wdata_rot = rot_right_bytes(mem_req.wdata, wr_rot);

  //////////////////////////////////////////////////
  // Byte lanes
  //////////////////////////////////////////////////

  for (genvar k = 0; k < 4; k++) begin : g_lane
    logic [7:0] lane_mem [`MW_MEM_WORDS];

    always_ff @(posedge bus) begin
      if (mem_req.wr && mem_req.byte_en[k]) begin
        lane_mem[word_idx] <= wdata_rot[8*k +: 8];
      end
      // Read register holds until the next read
      if (mem_req.rd) begin
        rd_lane[k] <= lane_mem[word_idx];
      end
    end
  end

  // Offset of the last read
  always_ff @(posedge bus) begin
    if (mem_req.rd) begin
      rd_off <= mem_req.addr[1:0];
    end
  end

  assign rd_word = {rd_lane[3], rd_lane[2], rd_lane[1], rd_lane[0]};

  // Addressed byte lands at bit 0
  assign rdata = rot_right_bytes(rd_word, rd_off);

  // Upper address bits would alias into the array
  a_addr_range: assert property (@(posedge bus)
    (mem_req.wr || mem_req.rd) |-> (mem_req.addr[`MW_XLEN-1:2] < `MW_MEM_WORDS))
    else $error("Data memory access outside %0d words", `MW_MEM_WORDS);

endmodule

//--- hdl/writeback_stage.sv
`timescale 1ns/100ps
`include "mem_defines.svh"

module writeback_stage (
  input  mem_pkg::mem_wb_t    mem_wb,
  input  logic [`MW_XLEN-1:0] memres,
  output logic [`MW_XLEN-1:0] wb_res,
  output mem_pkg::reg_wr_t    reg_wr
);

  //////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////

  // Load data first, then the long-latency units, ALU last
  always_comb begin
    if (mem_wb.memread) begin
      wb_res = memres;
    end else if (mem_wb.mul_ready) begin
      wb_res = mem_wb.mulres;
    end else if (mem_wb.div_ready) begin
      wb_res = mem_wb.divres;
    end else begin
      wb_res = mem_wb.alures;
    end
  end

  //////////////////////////////////////////////////
  // Register write port
  //////////////////////////////////////////////////

  // x0 is hardwired, so its writes are dropped here
  assign reg_wr.we   = mem_wb.regwrite && (mem_wb.rd != '0);
  assign reg_wr.rd   = mem_wb.rd;
  assign reg_wr.data = wb_res;

  // Execute stage never finishes a multiply and a divide together
  always_comb begin
    if (mem_wb.regwrite) begin
      a_mul_div_excl: assert final (!(mem_wb.mul_ready && mem_wb.div_ready))
        else $error("MEM/WB has mul_ready and div_ready both set");
    end
  end

endmodule

//--- hdl/mem_wb_top.sv
`timescale 1ns/100ps
`include "mem_defines.svh"

module mem_wb_top (
  input  logic             bus,
  input  logic             rst,
  input  logic             hold,
  input  mem_pkg::ex_mem_t ex_mem,
  output mem_pkg::reg_wr_t reg_wr
);

  //////////////////////////////////////////////////
  // Stage interconnect
  //////////////////////////////////////////////////

  mem_pkg::mem_req_t   mem_req;
  logic [`MW_XLEN-1:0] rdata;
  mem_pkg::mem_wb_t    mem_wb;
  logic [`MW_XLEN-1:0] memres;
  // Writeback value looped back for store forwarding
  logic [`MW_XLEN-1:0] wb_res;

  mem_stage mem_stage_i (
    .bus     (bus),
    .rst     (rst),
    .hold    (hold),
    .ex_mem  (ex_mem),
    .rdata   (rdata),
    .wb_res  (wb_res),
    .mem_req (mem_req),
    .mem_wb  (mem_wb),
    .memres  (memres)
  );

  data_mem data_mem_i (
    .bus     (bus),
    .mem_req (mem_req),
    .rdata   (rdata)
  );

  writeback_stage writeback_stage_i (
    .mem_wb (mem_wb),
    .memres (memres),
    .wb_res (wb_res),
    .reg_wr (reg_wr)
  );

endmodule

//--- tests/tb_mem_wb.sv
`timescale 1ns/100ps
`include "mem_defines.svh"

module tb_mem_wb;

  localparam int FILL_WORDS   = 64;
  localparam int PAIRS        = 16;
  localparam int FWD_ROUNDS   = 8;
  localparam int RAND_RECORDS = 200;
  // Idle, fill, store/load pairs, lane sweep, forwarding, select, random mix
  localparam int NUM_RECORDS  = 1 + FILL_WORDS + 2 * PAIRS + 48 + 3 * FWD_ROUNDS + 5
                                + RAND_RECORDS;
  localparam int WATCHDOG_NS  = NUM_RECORDS * 8 * 4 + 200;

  logic             bus = 1'b0;
  logic             rst;
  logic             rst_q = 1'b1;
  logic             hold;
  mem_pkg::ex_mem_t ex_mem;
  mem_pkg::reg_wr_t reg_wr;

  // LFSR state and hold enable
  logic [31:0] lfsr;
  logic        hold_en;
  // Model memory by byte, plus the record now in MEM/WB
  logic [7:0]                  model_mem [4*`MW_MEM_WORDS];
  logic [`MW_XLEN-1:0]         prev_wb;
  logic [`MW_REG_BITS-1:0]     prev_rd;
  logic                        prev_regwrite;
  mem_pkg::reg_wr_t            exp_q [$];
  int                          idx_q [$];
  int                          num_sent;
  int                          num_checks;
  int                          num_errors;

  mem_wb_top mem_wb_top_i (
    .bus    (bus),
    .rst    (rst),
    .hold   (hold),
    .ex_mem (ex_mem),
    .reg_wr (reg_wr)
  );

  initial begin
    forever #4 bus = ~bus;
  end

  //////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [`MW_REG_BITS-1:0] pick_reg(input int n);
    logic [31:0] v;
    v = take_bits(n);
    return v[`MW_REG_BITS-1:0];
  endfunction

  // Inside the first 64 words, which the fill phase defines
  function automatic logic [`MW_XLEN-1:0] pick_addr(input logic aligned);
    logic [31:0] w;
    logic [31:0] o;
    w = take_bits(6);
    o = aligned ? 32'h0 : take_bits(2);
    return {24'h0, w[5:0], o[1:0]};
  endfunction

  // Roughly one edge in four is held
  function automatic logic hold_draw();
    logic [31:0] v;
    if (!hold_en) return 1'b0;
    v = take_bits(2);
    return v[1:0] == 2'b00;
  endfunction

  function automatic mem_pkg::store_ctrl_e store_kind();
    logic [31:0] v;
    v = take_bits(2);
    case (v[1:0])
      2'd0:    return mem_pkg::st_sb;
      2'd1:    return mem_pkg::st_sh;
      default: return mem_pkg::st_sw;
    endcase
  endfunction

  function automatic mem_pkg::load_ctrl_e load_kind();
    logic [31:0] v;
    v = take_bits(3);
    case (v[2:0])
      3'd0:    return mem_pkg::ld_lb;
      3'd1:    return mem_pkg::ld_lh;
      3'd3:    return mem_pkg::ld_lbu;
      3'd4:    return mem_pkg::ld_lhu;
      default: return mem_pkg::ld_lw;
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Record builders
  //////////////////////////////////////////////////

  function automatic mem_pkg::ex_mem_t store_rec(input mem_pkg::store_ctrl_e kind,
      input logic [31:0] addr, input logic [31:0] data, input logic [4:0] rs2);
    mem_pkg::ex_mem_t rec;
    rec           = '0;
    rec.alures    = addr;
    rec.rs2_data  = data;
    rec.rs2       = rs2;
    rec.memwrite  = 1'b1;
    rec.storectrl = kind;
    return rec;
  endfunction

  function automatic mem_pkg::ex_mem_t load_rec(input mem_pkg::load_ctrl_e kind,
      input logic [31:0] addr, input logic [4:0] rd);
    mem_pkg::ex_mem_t rec;
    logic [31:0]      v;
    rec          = '0;
    rec.alures   = addr;
    rec.rd       = rd;
    rec.regwrite = 1'b1;
    rec.memread  = 1'b1;
    rec.loadctrl = kind;
    // Stale unit results that must not win over load data
    rec.mulres   = take_bits(32);
    rec.divres   = take_bits(32);
    // One ready flag raised, so load data has to beat it
    v             = take_bits(1);
    rec.mul_ready = v[0];
    rec.div_ready = !v[0];
    return rec;
  endfunction

  function automatic mem_pkg::ex_mem_t alu_rec(input logic [4:0] rd, input logic regwrite,
      input logic mul_ready, input logic div_ready);
    mem_pkg::ex_mem_t rec;
    rec           = '0;
    rec.rd        = rd;
    rec.regwrite  = regwrite;
    rec.alures    = take_bits(32);
    rec.mulres    = take_bits(32);
    rec.mul_ready = mul_ready;
    rec.divres    = take_bits(32);
    rec.div_ready = div_ready;
    return rec;
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Byte i of a store lands in lane (offset + i) mod 4 of the same word
  function automatic mem_pkg::reg_wr_t expected_reg_wr(input mem_pkg::ex_mem_t rec);
    mem_pkg::reg_wr_t exp;
    logic [31:0]      data;
    logic [31:0]      word;
    logic [31:0]      res;
    logic [1:0]       lane;
    int               nbytes;
    exp.we = rec.regwrite && (rec.rd != '0);
    exp.rd = rec.rd;
    if (rec.memwrite) begin
      // MEM/WB result replaces rs2_data when it writes rs2
      data = (prev_regwrite && prev_rd == rec.rs2) ? prev_wb : rec.rs2_data;
      case (rec.storectrl)
        mem_pkg::st_sb: nbytes = 1;
        mem_pkg::st_sh: nbytes = 2;
        default:        nbytes = 4;
      endcase
      for (int i = 0; i < nbytes; i++) begin
        lane = rec.alures[1:0] + i[1:0];
        model_mem[{rec.alures[`MW_MEM_ADDR_BITS+1:2], lane}] = data[7:0];
        data = data >> 8;
      end
    end
    if (rec.memread) begin
      word = '0;
      // Addressed byte ends up in bits 7:0
      for (int i = 0; i < 4; i++) begin
        lane = rec.alures[1:0] + i[1:0];
        word = {model_mem[{rec.alures[`MW_MEM_ADDR_BITS+1:2], lane}], word[31:8]};
      end
      case (rec.loadctrl)
        mem_pkg::ld_lb:  res = {{24{word[7]}}, word[7:0]};
        mem_pkg::ld_lh:  res = {{16{word[15]}}, word[15:0]};
        mem_pkg::ld_lw:  res = word;
        mem_pkg::ld_lbu: res = {24'h0, word[7:0]};
        mem_pkg::ld_lhu: res = {16'h0, word[15:0]};
        default:         res = '0;
      endcase
    end else if (rec.mul_ready) begin
      res = rec.mulres;
    end else if (rec.div_ready) begin
      res = rec.divres;
    end else begin
      res = rec.alures;
    end
    exp.data      = res;
    prev_wb       = res;
    prev_rd       = rec.rd;
    prev_regwrite = rec.regwrite;
    return exp;
  endfunction

  //////////////////////////////////////////////////
  // Driver and compare
  //////////////////////////////////////////////////

  // Called right after a rising edge, returns at the accepting edge
  task automatic send_record(input mem_pkg::ex_mem_t rec);
    ex_mem <= rec;
    hold   <= hold_draw();
    @(posedge bus);
    while (hold) begin
      hold <= hold_draw();
      @(posedge bus);
    end
    exp_q.push_back(expected_reg_wr(rec));
    idx_q.push_back(num_sent);
    num_sent++;
  endtask

  // rd and data only matter when a write is expected
  task automatic check_reg_wr(input mem_pkg::reg_wr_t got, input mem_pkg::reg_wr_t exp,
      input int idx);
    string what;
    what = (idx < 0) ? "reset" : $sformatf("record %0d", idx);
    num_checks++;
    if (got.we !== exp.we || (exp.we && (got.rd !== exp.rd || got.data !== exp.data))) begin
      num_errors++;
      $display("ERROR %0t: %s reg_wr we=%0b rd=%0d data=%h, expected we=%0b rd=%0d data=%h",
               $time, what, got.we, got.rd, got.data, exp.we, exp.rd, exp.data);
    end
  endtask

  always @(posedge bus) rst_q <= rst;

  // Mid-cycle, one compare per accepted record
  always @(negedge bus) begin
    if (rst || rst_q) begin
      check_reg_wr(reg_wr, '0, -1);
    end else if (exp_q.size() > 0) begin
      check_reg_wr(reg_wr, exp_q.pop_front(), idx_q.pop_front());
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: no end of test after %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    logic [31:0]         a;
    logic [31:0]         b;
    logic [31:0]         v;
    mem_pkg::load_ctrl_e sweep [5];
    sweep = '{mem_pkg::ld_lb, mem_pkg::ld_lbu, mem_pkg::ld_lh, mem_pkg::ld_lhu, mem_pkg::ld_lw};
    lfsr          = 32'hd7200255;
    hold_en       = 1'b0;
    rst           = 1'b1;
    hold          = 1'b0;
    ex_mem        = '0;
    prev_wb       = '0;
    prev_rd       = '0;
    prev_regwrite = 1'b0;
    num_sent      = 0;
    num_checks    = 0;
    num_errors    = 0;
    repeat (3) @(posedge bus);
    rst <= 1'b0;
    send_record('0);
    // Define the test region with whole words
    for (int w = 0; w < FILL_WORDS; w++) begin
      send_record(store_rec(mem_pkg::st_sw, w * 4, take_bits(32), 5'd0));
    end
    for (int p = 0; p < PAIRS; p++) begin
      a = pick_addr(1'b1);
      send_record(store_rec(mem_pkg::st_sw, a, take_bits(32), pick_reg(5)));
      send_record(load_rec(mem_pkg::ld_lw, a, pick_reg(5)));
    end
    // SB then SH at each offset, each read back five ways
    a = pick_addr(1'b1);
    for (int k = 0; k < 2; k++) begin
      for (int off = 0; off < 4; off++) begin
        send_record(store_rec((k == 0) ? mem_pkg::st_sb : mem_pkg::st_sh, a + off,
                              take_bits(32), 5'd10));
        for (int j = 0; j < 5; j++) begin
          send_record(load_rec(sweep[j], a + off, 5'(j + 1)));
        end
      end
    end
    // Load, dependent store, read back
    for (int r = 0; r < FWD_ROUNDS; r++) begin
      a = pick_addr(1'b0);
      b = pick_addr(1'b0);
      send_record(load_rec(load_kind(), a, 5'(r + 1)));
      send_record(store_rec(store_kind(), b, take_bits(32), 5'(r + 1)));
      send_record(load_rec(mem_pkg::ld_lw, b, 5'd20));
    end
    send_record(alu_rec(5'd7, 1'b1, 1'b1, 1'b0));
    send_record(alu_rec(5'd8, 1'b1, 1'b0, 1'b1));
    send_record(alu_rec(5'd9, 1'b1, 1'b0, 1'b0));
    send_record(alu_rec(5'd0, 1'b1, 1'b0, 1'b0));
    send_record(alu_rec(5'd10, 1'b0, 1'b1, 1'b0));
    // Mixed traffic under random back-pressure, small register set
    hold_en = 1'b1;
    for (int n = 0; n < RAND_RECORDS; n++) begin
      v = take_bits(2);
      case (v[1:0])
        2'd0:    send_record(store_rec(store_kind(), pick_addr(1'b0), take_bits(32),
                                       pick_reg(3)));
        2'd1:    send_record(load_rec(load_kind(), pick_addr(1'b0), pick_reg(3)));
        default: begin
          v = take_bits(3);
          send_record(alu_rec(pick_reg(3), v[0], v[2:1] == 2'd1, v[2:1] == 2'd2));
        end
      endcase
    end
    ex_mem <= '0;
    hold   <= 1'b0;
    @(negedge bus);
    @(negedge bus);
    if (exp_q.size() != 0) begin
      $display("Records still waiting for a compare: %0d", exp_q.size());
      num_errors++;
    end
    $display("Records %0d, checks %0d, errors %0d", num_sent, num_checks, num_errors);
    if (num_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
hdl/mem_pkg.sv
hdl/mem_stage.sv
hdl/data_mem.sv
hdl/writeback_stage.sv
hdl/mem_wb_top.sv
tests/tb_mem_wb.sv

//--- Makefile
# Verilator build and run of the memory and writeback back end

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mem_wb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

# Status is taken from the pass line in the simulation output
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
